//--- sim/rvCoreVectors.mem
// Columns: kind address data, all hex
// Kind 0 program word, 1 initial data word, 2 expected store in order, 3 halt PC
0 00000000 06400093 // addi x1, x0, 100
0 00000004 FF900113 // addi x2, x0, -7
0 00000008 002081B3 // add x3, x1, x2
0 0000000C 10302023 // sw x3, 0x100(x0)
0 00000010 402081B3 // sub
0 00000014 10302223
0 00000018 0020F1B3 // and
0 0000001C 10302423
0 00000020 0020E1B3 // or
0 00000024 10302623
0 00000028 0020C1B3 // xor
0 0000002C 10302823
0 00000030 03C0F193 // andi x3, x1, 0x3c
0 00000034 10302A23
0 00000038 7030E193 // ori x3, x1, 0x703
0 0000003C 10302C23
0 00000040 55514193 // xori x3, x2, 0x555
0 00000044 10302E23
0 00000048 00400213 // addi x4, x0, 4
0 0000004C 004111B3 // sll x3, x2, x4
0 00000050 12302023
0 00000054 004151B3 // srl
0 00000058 12302223
0 0000005C 404151B3 // sra
0 00000060 12302423
0 00000064 40115193 // srai x3, x2, 1
0 00000068 12302623
0 0000006C 001121B3 // slt x3, x2, x1
0 00000070 12302823
0 00000074 001131B3 // sltu
0 00000078 12302A23
0 0000007C 20002283 // lw x5, 0x200(x0)
0 00000080 11128293 // addi x5, x5, 0x111
0 00000084 20502223 // sw x5, 0x204(x0)
0 00000088 20402303 // lw x6, 0x204(x0)
0 0000008C 20602423 // sw x6, 0x208(x0)
0 00000090 04E00493 // addi x9, x0, 0x4e  not-taken marker
0 00000094 05400513 // addi x10, x0, 0x54  taken marker
0 00000098 00208463 // beq x1, x2, +8
0 0000009C 30902023
0 000000A0 30A02023
0 000000A4 00209463 // bne x1, x2, +8
0 000000A8 30902223
0 000000AC 30A02223
0 000000B0 00114463 // blt x2, x1, +8
0 000000B4 30902423
0 000000B8 30A02423
0 000000BC 00115463 // bge x2, x1, +8
0 000000C0 30902623
0 000000C4 30A02623
0 000000C8 00116463 // bltu x2, x1, +8
0 000000CC 30902823
0 000000D0 30A02823
0 000000D4 00117463 // bgeu x2, x1, +8
0 000000D8 30902A23
0 000000DC 30A02A23
0 000000E0 008005EF // jal x11, +8
0 000000E4 3E902E23 // skipped store
0 000000E8 40B02023 // sw x11, 0x400(x0)
0 000000EC 00000617 // auipc x12, 0
0 000000F0 00D606E7 // jalr x13, 13(x12)
0 000000F4 3E902E23 // skipped store
0 000000F8 40D02223 // sw x13, 0x404(x0)
0 000000FC ABCDE7B7 // lui x15, 0xabcde
0 00000100 40F02423
0 00000104 12345717 // auipc x14, 0x12345
0 00000108 40E02623
0 0000010C 00000073 // ecall
1 00000200 12345678
2 00000100 0000005D
2 00000104 0000006B
2 00000108 00000060
2 0000010C FFFFFFFD
2 00000110 FFFFFF9D
2 00000114 00000024
2 00000118 00000767
2 0000011C FFFFFAAC
2 00000120 FFFFFF90
2 00000124 0FFFFFFF
2 00000128 FFFFFFFF
2 0000012C FFFFFFFC
2 00000130 00000001
2 00000134 00000000
2 00000204 12345789
2 00000208 12345789
2 00000300 0000004E
2 00000300 00000054
2 00000304 00000054
2 00000308 00000054
2 0000030C 0000004E
2 0000030C 00000054
2 00000310 0000004E
2 00000310 00000054
2 00000314 00000054
2 00000400 000000E4
2 00000404 000000F4
2 00000408 ABCDE000
2 0000040C 12345104
3 0000010C 00000000

//--- tb.f
common/rvIsaPkg.sv
common/corePkg.sv
common/ctrlIf.sv
decode/instrDecoder.sv
decode/regFile.sv
execute/execUnit.sv
src/retireUnit.sv
src/rvCore.sv
sim/rvCoreAssertions.sv
sim/rvCoreTb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module rvCoreTb -f tb.f -Mdir obj_dir
	./obj_dir/VrvCoreTb | tee sim.log
	@grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/rvCoreTb.sv
`default_nettype none

module rvCoreTb;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 1;
	localparam int HALT_HOLD = 4;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 512;
	localparam int VEC_WORDS = 768; // 256 records of three words
	localparam logic [31:0] END_MARK = 32'hFFFFFFFF;

	logic clk;
	logic rst;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	logic [31:0] dmemAddr;
	logic [31:0] dmemWdata;
	logic [31:0] dmemRdata;
	logic dmemWe;

	logic [31:0] vecWords [VEC_WORDS];
	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] haltPc;
	bit vecLoaded;
	int progWords;
	int badRecords;
	int storeIndex;
	int testCount;
	int passCount;
	int errorCount;

	rvCore rvCore_inst (
		.clk(clk),
		.rst(rst),
		.imemAddr_o(imemAddr),
		.imemData_i(imemData),
		.dmemAddr_o(dmemAddr),
		.dmemWdata_o(dmemWdata),
		.dmemWe_o(dmemWe),
		.dmemRdata_i(dmemRdata)
	);

	// Zero during reset, decodes as a no-op
	assign imemData = rst ? '0 : imem[imemAddr[9:2]];
	assign dmemRdata = dmem[dmemAddr[10:2]];

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic loadVectors();
		int i;
		logic [31:0] kind;
		logic [31:0] addr;
		logic [31:0] data;
		progWords = 0;
		badRecords = 0;
		haltPc = END_MARK;
		for (i = 0; i < IMEM_WORDS; i++)
			imem[i] = {i[24:0], 7'b0000000}; // Opcode field stays zero
		for (i = 0; i < DMEM_WORDS; i++)
			dmem[i] <= 32'hDA7A0000 ^ i;
		for (i = 0; i < VEC_WORDS; i++)
			vecWords[i] = END_MARK;
		$readmemh("sim/rvCoreVectors.mem", vecWords);
		i = 0;
		while (i + 2 < VEC_WORDS && vecWords[i] != END_MARK) begin
			kind = vecWords[i];
			addr = vecWords[i + 1];
			data = vecWords[i + 2];
			case (kind)
				32'h0: begin
					imem[addr[9:2]] = data;
					progWords++;
				end
				32'h1: dmem[addr[10:2]] <= data;
				32'h2: begin
					expAddr.push_back(addr);
					expData.push_back(data);
				end
				32'h3: haltPc = addr;
				default: badRecords++;
			endcase
			i += 3;
		end
		vecLoaded = 1'b1;
	endtask

	// Data memory, written on the edge that ends the store's cycle
	initial begin
		loadVectors();
		forever begin
			@(posedge clk);
			if (!rst && dmemWe)
				dmem[dmemAddr[10:2]] <= dmemWdata;
		end
	end

	task automatic checkStore();
		bit ok;
		ok = 1'b1;
		testCount++;
		if (storeIndex >= expAddr.size()) begin
			$display("Store to %h with data %h came after the last expected store",
				dmemAddr, dmemWdata);
			errorCount++;
		end else begin
			if (dmemAddr !== expAddr[storeIndex]) begin
				$display("[ERROR] store %0d: dmemAddr_o = %h, expected %h",
					storeIndex, dmemAddr, expAddr[storeIndex]);
				ok = 1'b0;
			end
			if (dmemWdata !== expData[storeIndex]) begin
				$display("[ERROR] store %0d: dmemWdata_o = %h, expected %h",
					storeIndex, dmemWdata, expData[storeIndex]);
				ok = 1'b0;
			end
			if (ok)
				passCount++;
			else
				errorCount++;
			$display("Store %0d at %h: %s", storeIndex, expAddr[storeIndex],
				ok ? "pass" : "FAIL");
			storeIndex++;
		end
	endtask

	// Outputs sampled mid-cycle, where they are settled
	task automatic runToHalt();
		bit atHalt;
		atHalt = 1'b0;
		while (!atHalt) begin
			@(negedge clk);
			if (dmemWe)
				checkStore();
			if (imemAddr == haltPc)
				atHalt = 1'b1;
		end
	endtask

	task automatic checkHalt();
		int cyc;
		bit ok;
		ok = 1'b1;
		for (cyc = 0; cyc < HALT_HOLD; cyc++) begin
			@(negedge clk);
			if (imemAddr !== haltPc) begin
				$display("[ERROR] halt cycle %0d: imemAddr_o = %h, expected %h",
					cyc, imemAddr, haltPc);
				ok = 1'b0;
			end
			if (dmemWe) begin
				$display("A store to %h was issued while halted", dmemAddr);
				ok = 1'b0;
			end
		end
		if (storeIndex != expAddr.size()) begin
			$display("Only %0d of %0d expected stores were seen", storeIndex, expAddr.size());
			ok = 1'b0;
		end
		testCount++;
		if (ok)
			passCount++;
		else
			errorCount++;
		$display("Halt at %h: %s", haltPc, ok ? "pass" : "FAIL");
	endtask

	initial begin
		rst = 1'b1;
		storeIndex = 0;
		testCount = 0;
		passCount = 0;
		errorCount = 0;
		wait (vecLoaded);
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		runToHalt();
		checkHalt();
		if (badRecords != 0) begin
			$display("%0d records in the vector file have an unknown kind", badRecords);
			errorCount++;
		end
		if (rvCore_inst.coreAssertions_inst.failCount != 0) begin
			$display("Bound assertions failed %0d times",
				rvCore_inst.coreAssertions_inst.failCount);
			errorCount++;
		end
		$display("Tests: %0d, passed: %0d, errors: %0d", testCount, passCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// Watchdog, scaled by program length
	initial begin
		wait (vecLoaded);
		#(CLK_PERIOD * (RESET_CYCLES + 8 * progWords + 50));
		$display("Timeout: the halt PC %h was not reached in time", haltPc);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/rvCoreAssertions.sv
`default_nettype none

module rvCoreAssertions (
	input logic clk,
	input logic rst,
	input logic [rvIsaPkg::XLEN-1:0] imemAddr_i,
	input logic [rvIsaPkg::XLEN-1:0] dmemAddr_i,
	input logic [rvIsaPkg::XLEN-1:0] dmemWdata_i,
	input logic dmemWe_i
);

	int imemFails = 0;
	int storeFails = 0;
	int unknownFails = 0;
	int failCount;

	assign failCount = imemFails + storeFails + unknownFails;

	// Fetch stays on word boundaries
	assert property (@(posedge clk) disable iff (rst) imemAddr_i[1:0] == 2'b00)
	else begin
		$error("imemAddr_o misaligned: %h", imemAddr_i);
		imemFails++;
	end

	assert property (@(posedge clk) disable iff (rst) dmemWe_i |-> dmemAddr_i[1:0] == 2'b00)
	else begin
		$error("store to misaligned dmemAddr_o: %h", dmemAddr_i);
		storeFails++;
	end

	assert property (@(posedge clk) disable iff (rst)
		!$isunknown({imemAddr_i, dmemAddr_i, dmemWdata_i, dmemWe_i}))
	else begin
		$error("unknown value on a core output");
		unknownFails++;
	end

endmodule

bind rvCore rvCoreAssertions coreAssertions_inst (
	.clk(clk),
	.rst(rst),
	.imemAddr_i(imemAddr_o),
	.dmemAddr_i(dmemAddr_o),
	.dmemWdata_i(dmemWdata_o),
	.dmemWe_i(dmemWe_o)
);

`default_nettype wire

//--- src/rvCore.sv
`default_nettype none

module rvCore (
	input  logic clk,
	input  logic rst,
	output logic [rvIsaPkg::XLEN-1:0] imemAddr_o,
	input  logic [rvIsaPkg::XLEN-1:0] imemData_i,
	output logic [rvIsaPkg::XLEN-1:0] dmemAddr_o,
	output logic [rvIsaPkg::XLEN-1:0] dmemWdata_o,
	output logic dmemWe_o,
	input  logic [rvIsaPkg::XLEN-1:0] dmemRdata_i
);

	ctrlIf ctrl ();

	logic [rvIsaPkg::REG_ADDR_W-1:0] rs1Addr, rs2Addr, rdAddr;
	logic [rvIsaPkg::XLEN-1:0] rs1Data, rs2Data;
	logic [rvIsaPkg::XLEN-1:0] aluResult, pcTarget, redirectAddr;
	logic [rvIsaPkg::XLEN-1:0] pc, wbData;
	logic redirect;

	instrDecoder decoder_inst (
		.instr_i(imemData_i),
		.ctrl(ctrl.decoder),
		.rs1Addr_o(rs1Addr),
		.rs2Addr_o(rs2Addr),
		.rdAddr_o(rdAddr)
	);

	regFile regFile_inst (
		.clk(clk),
		.rst(rst),
		.rs1Addr_i(rs1Addr),
		.rs2Addr_i(rs2Addr),
		.rdAddr_i(rdAddr),
		.rdWe_i(ctrl.regWrite),
		.rdData_i(wbData),
		.rs1Data_o(rs1Data),
		.rs2Data_o(rs2Data)
	);

	execUnit exec_inst (
		.ctrl(ctrl.exec),
		.pc_i(pc),
		.rs1_i(rs1Data),
		.rs2_i(rs2Data),
		.aluResult_o(aluResult),
		.pcTarget_o(pcTarget),
		.redirectAddr_o(redirectAddr),
		.redirect_o(redirect)
	);

	retireUnit retire_inst (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl.retire),
		.redirect_i(redirect),
		.redirectAddr_i(redirectAddr),
		.aluResult_i(aluResult),
		.pcTarget_i(pcTarget),
		.memData_i(dmemRdata_i),
		.pc_o(pc),
		.wbData_o(wbData)
	);

	assign imemAddr_o = pc;
	assign dmemAddr_o = aluResult; // rs1 + imm for loads and stores
	assign dmemWdata_o = rs2Data;
	assign dmemWe_o = ctrl.memWrite;

endmodule

`default_nettype wire

//--- src/retireUnit.sv
`default_nettype none

module retireUnit (
	input  logic clk,
	input  logic rst,
	ctrlIf.retire ctrl,
	input  logic redirect_i,
	input  logic [rvIsaPkg::XLEN-1:0] redirectAddr_i,
	input  logic [rvIsaPkg::XLEN-1:0] aluResult_i,
	input  logic [rvIsaPkg::XLEN-1:0] pcTarget_i,
	input  logic [rvIsaPkg::XLEN-1:0] memData_i,
	output logic [rvIsaPkg::XLEN-1:0] pc_o,
	output logic [rvIsaPkg::XLEN-1:0] wbData_o
);

	logic [rvIsaPkg::XLEN-1:0] pcPlus4;
	logic [rvIsaPkg::XLEN-1:0] pcNext;

	assign pcPlus4 = pc_o + corePkg::PC_STEP;

	// Halt wins over redirect
	always_comb begin
		if (ctrl.isHalt)
			pcNext = pc_o;
		else if (redirect_i)
			pcNext = redirectAddr_i;
		else
			pcNext = pcPlus4;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc_o <= corePkg::RESET_PC;
		else
			pc_o <= pcNext;
	end

	always_comb begin
		case (ctrl.resultSrc)
			corePkg::RES_MEM: wbData_o = memData_i;
			corePkg::RES_PC4: wbData_o = pcPlus4; // Link address
			corePkg::RES_IMM: wbData_o = ctrl.imm;
			corePkg::RES_PCTARGET: wbData_o = pcTarget_i;
			default: wbData_o = aluResult_i;
		endcase
	end

endmodule

`default_nettype wire

//--- execute/execUnit.sv
`default_nettype none

module execUnit (
	ctrlIf.exec ctrl,
	input  logic [rvIsaPkg::XLEN-1:0] pc_i,
	input  logic [rvIsaPkg::XLEN-1:0] rs1_i,
	input  logic [rvIsaPkg::XLEN-1:0] rs2_i,
	output logic [rvIsaPkg::XLEN-1:0] aluResult_o,
	output logic [rvIsaPkg::XLEN-1:0] pcTarget_o,
	output logic [rvIsaPkg::XLEN-1:0] redirectAddr_o,
	output logic redirect_o
);

	logic [rvIsaPkg::XLEN-1:0] srcB;
	logic [corePkg::SHAMT_W-1:0] shamt;
	logic zero;
	logic brTaken;

	assign srcB = ctrl.aluSrcImm ? ctrl.imm : rs2_i;
	assign shamt = srcB[corePkg::SHAMT_W-1:0];

	always_comb begin
		aluResult_o = '0;
		case (ctrl.aluOp)
			corePkg::ALU_ADD: aluResult_o = rs1_i + srcB;
			corePkg::ALU_SUB: aluResult_o = rs1_i - srcB;
			corePkg::ALU_AND: aluResult_o = rs1_i & srcB;
			corePkg::ALU_OR: aluResult_o = rs1_i | srcB;
			corePkg::ALU_XOR: aluResult_o = rs1_i ^ srcB;
			corePkg::ALU_SLT: aluResult_o[0] = $signed(rs1_i) < $signed(srcB);
			corePkg::ALU_SLTU: aluResult_o[0] = rs1_i < srcB;
			corePkg::ALU_SLL: aluResult_o = rs1_i << shamt;
			corePkg::ALU_SRL: aluResult_o = rs1_i >> shamt; // Logical, on rs1
			corePkg::ALU_SRA: aluResult_o = $signed(rs1_i) >>> shamt;
			default: aluResult_o = '0;
		endcase
	end

	assign zero = (aluResult_o == '0);

	// SUB result for equality, compare bit for the ordered pairs
	always_comb begin
		case (ctrl.brCond)
			rvIsaPkg::BEQ: brTaken = zero;
			rvIsaPkg::BNE: brTaken = !zero;
			rvIsaPkg::BLT, rvIsaPkg::BLTU: brTaken = aluResult_o[0];
			rvIsaPkg::BGE, rvIsaPkg::BGEU: brTaken = !aluResult_o[0];
			default: brTaken = 1'b0;
		endcase
	end

	assign pcTarget_o = pc_i + ctrl.imm;
	assign redirect_o = (ctrl.isBranch && brTaken) || ctrl.isJal || ctrl.isJalr;

	// JALR clears bit 0 of rs1 + imm
	assign redirectAddr_o = ctrl.isJalr ? {aluResult_o[rvIsaPkg::XLEN-1:1], 1'b0} : pcTarget_o;

endmodule

`default_nettype wire

//--- decode/regFile.sv
`default_nettype none

module regFile (
	input  logic clk,
	input  logic rst,
	input  logic [rvIsaPkg::REG_ADDR_W-1:0] rs1Addr_i,
	input  logic [rvIsaPkg::REG_ADDR_W-1:0] rs2Addr_i,
	input  logic [rvIsaPkg::REG_ADDR_W-1:0] rdAddr_i,
	input  logic rdWe_i,
	input  logic [rvIsaPkg::XLEN-1:0] rdData_i,
	output logic [rvIsaPkg::XLEN-1:0] rs1Data_o,
	output logic [rvIsaPkg::XLEN-1:0] rs2Data_o
);

	logic [rvIsaPkg::XLEN-1:0] regs [corePkg::NUM_REGS];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < corePkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (rdWe_i && rdAddr_i != '0) begin // x0 stays zero
			regs[rdAddr_i] <= rdData_i;
		end
	end

	// Combinational read
	assign rs1Data_o = (rs1Addr_i == '0) ? '0 : regs[rs1Addr_i];
	assign rs2Data_o = (rs2Addr_i == '0) ? '0 : regs[rs2Addr_i];

endmodule

`default_nettype wire

//--- decode/instrDecoder.sv
`default_nettype none

module instrDecoder (
	input  rvIsaPkg::instr_u instr_i,
	ctrlIf.decoder ctrl,
	output logic [rvIsaPkg::REG_ADDR_W-1:0] rs1Addr_o,
	output logic [rvIsaPkg::REG_ADDR_W-1:0] rs2Addr_o,
	output logic [rvIsaPkg::REG_ADDR_W-1:0] rdAddr_o
);

	logic [rvIsaPkg::XLEN-1:0] immI, immS, immB, immU, immJ;
	logic altFunct; // funct7 bit 5, SUB and SRA select
	corePkg::aluOp_e functOp, branchOp;

	assign rs1Addr_o = instr_i.rType.rs1;
	assign rs2Addr_o = instr_i.rType.rs2;
	assign rdAddr_o = instr_i.rType.rd;
	assign altFunct = instr_i.rType.funct7[5];

	// Sign-extended immediates, one per format view
	assign immI = {{20{instr_i.iType.imm11_0[11]}}, instr_i.iType.imm11_0};
	assign immS = {{20{instr_i.sType.imm11_5[6]}}, instr_i.sType.imm11_5, instr_i.sType.imm4_0};
	assign immB = {{19{instr_i.bType.imm12}}, instr_i.bType.imm12, instr_i.bType.imm11,
		instr_i.bType.imm10_5, instr_i.bType.imm4_1, 1'b0};
	assign immU = {instr_i.uType.imm31_12, 12'b0};
	assign immJ = {{11{instr_i.jType.imm20}}, instr_i.jType.imm20, instr_i.jType.imm19_12,
		instr_i.jType.imm11, instr_i.jType.imm10_1, 1'b0};

	// Shared by register and immediate forms
	always_comb begin
		case (instr_i.rType.funct3)
			3'b000: begin
				if (altFunct && instr_i.rType.opcode == rvIsaPkg::OP_R)
					functOp = corePkg::ALU_SUB;
				else
					functOp = corePkg::ALU_ADD; // ADDI has no SUB form
			end
			3'b001: functOp = corePkg::ALU_SLL;
			3'b010: functOp = corePkg::ALU_SLT;
			3'b011: functOp = corePkg::ALU_SLTU;
			3'b100: functOp = corePkg::ALU_XOR;
			3'b101: functOp = altFunct ? corePkg::ALU_SRA : corePkg::ALU_SRL;
			3'b110: functOp = corePkg::ALU_OR;
			default: functOp = corePkg::ALU_AND;
		endcase
	end

	// Compare op per branch pair
	always_comb begin
		case (instr_i.bType.funct3[2:1])
			2'b00: branchOp = corePkg::ALU_SUB; // BEQ, BNE
			2'b10: branchOp = corePkg::ALU_SLT; // BLT, BGE
			2'b11: branchOp = corePkg::ALU_SLTU; // BLTU, BGEU
			default: branchOp = corePkg::ALU_ADD;
		endcase
	end

	assign ctrl.brCond = instr_i.bType.funct3;

	always_comb begin
		ctrl.aluOp = corePkg::ALU_ADD;
		ctrl.aluSrcImm = 1'b0;
		ctrl.isBranch = 1'b0;
		ctrl.isJal = 1'b0;
		ctrl.isJalr = 1'b0;
		ctrl.isHalt = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.resultSrc = corePkg::RES_ALU;
		ctrl.imm = '0;
		case (instr_i.rType.opcode)
			rvIsaPkg::OP_R: begin
				ctrl.aluOp = functOp;
				ctrl.regWrite = 1'b1;
			end
			rvIsaPkg::OP_IMM: begin
				ctrl.aluOp = functOp;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.imm = immI;
			end
			rvIsaPkg::OP_LOAD: begin // Word loads only
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.resultSrc = corePkg::RES_MEM;
				ctrl.imm = immI;
			end
			rvIsaPkg::OP_STORE: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.imm = immS;
			end
			rvIsaPkg::OP_BRANCH: begin
				ctrl.aluOp = branchOp;
				ctrl.isBranch = 1'b1;
				ctrl.imm = immB;
			end
			rvIsaPkg::OP_JAL: begin
				ctrl.isJal = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.resultSrc = corePkg::RES_PC4;
				ctrl.imm = immJ;
			end
			rvIsaPkg::OP_JALR: begin
				ctrl.aluSrcImm = 1'b1; // Target is rs1 + imm through the ALU
				ctrl.isJalr = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.resultSrc = corePkg::RES_PC4;
				ctrl.imm = immI;
			end
			rvIsaPkg::OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.resultSrc = corePkg::RES_IMM;
				ctrl.imm = immU;
			end
			rvIsaPkg::OP_AUIPC: begin
				ctrl.regWrite = 1'b1;
				ctrl.resultSrc = corePkg::RES_PCTARGET;
				ctrl.imm = immU;
			end
			rvIsaPkg::OP_SYSTEM: ctrl.isHalt = 1'b1; // ECALL and EBREAK
			default: ; // FENCE and unknown opcodes
		endcase
	end

endmodule

`default_nettype wire

//--- common/ctrlIf.sv
`default_nettype none

interface ctrlIf;

	corePkg::aluOp_e aluOp;
	logic aluSrcImm; // Operand B is imm, else rs2
	logic isBranch;
	logic [2:0] brCond; // Branch funct3
	logic isJal;
	logic isJalr;
	logic isHalt;
	logic memWrite;
	logic regWrite;
	corePkg::resultSrc_e resultSrc;
	logic [rvIsaPkg::XLEN-1:0] imm;

	modport decoder (
		output aluOp, aluSrcImm, isBranch, brCond, isJal, isJalr, isHalt,
		output memWrite, regWrite, resultSrc, imm
	);

	modport exec (input aluOp, aluSrcImm, isBranch, brCond, isJal, isJalr, imm);

	// Immediate is needed here for the LUI write-back
	modport retire (input isHalt, resultSrc, imm);

endinterface

`default_nettype wire

//--- common/corePkg.sv
`default_nettype none

package corePkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} aluOp_e;

	// Write-back source
	typedef enum logic [2:0] {
		RES_ALU,
		RES_MEM,
		RES_PC4,
		RES_IMM,
		RES_PCTARGET
	} resultSrc_e;

	localparam int NUM_REGS = 1 << rvIsaPkg::REG_ADDR_W;
	localparam int SHAMT_W = 5; // Shift amount bits taken from operand B

	localparam logic [rvIsaPkg::XLEN-1:0] PC_STEP = 4;
	localparam logic [rvIsaPkg::XLEN-1:0] RESET_PC = '0;

endpackage

`default_nettype wire

//--- common/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	// Major opcodes, FENCE left out on purpose so it falls to the no-op default
	typedef enum logic [6:0] {
		OP_R      = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	localparam logic [2:0] BEQ  = 3'b000;
	localparam logic [2:0] BNE  = 3'b001;
	localparam logic [2:0] BLT  = 3'b100;
	localparam logic [2:0] BGE  = 3'b101;
	localparam logic [2:0] BLTU = 3'b110;
	localparam logic [2:0] BGEU = 3'b111;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rType_t;

	typedef struct packed {
		logic [11:0] imm11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iType_t;

	typedef struct packed {
		logic [6:0] imm11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4_0;
		logic [6:0] opcode;
	} sType_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} bType_t;

	typedef struct packed {
		logic [19:0] imm31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} uType_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jType_t;

	// One instruction word, one view per encoding format
	typedef union packed {
		rType_t rType;
		iType_t iType;
		sType_t sType;
		bType_t bType;
		uType_t uType;
		jType_t jType;
	} instr_u;

endpackage

`default_nettype wire
